//--- tb.f
source/ising_cfg_pkg.sv
source/ising_bus_pkg.sv
source/ising_wb_if.sv
source/ising_array_if.sv
source/ising_bus_decode.sv
source/ising_l1_mem.sv
source/ising_regs.sv
source/ising_anneal_ctrl.sv
source/ising_spin_array.sv
source/ising_core_top.sv
bench/ising_core_tb.sv

//--- Makefile
# Verilator build for the Ising core testbench
# override on the command line, e.g. make sim TOP=ising_core_tb VFLAGS="--timing"

VERILATOR ?= verilator
TOP       ?= ising_core_tb
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal
LINTFLAGS ?= --timing

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

$(SIM_BIN): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# a $fatal in the testbench gives a non-zero exit status
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/ising_core_tb.sv
// drives the host Wishbone port only; the memories have no reset, so only written words are read
`timescale 1ns/1ps

module ising_core_tb;
    import ising_cfg_pkg::*;
    import ising_bus_pkg::*;

    localparam int ACK_TIMEOUT  = 500;   // cycles per bus access
    localparam int POLL_TIMEOUT = 200;   // STATUS reads per wait

    logic     clk;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    integer   seed;

    // problem currently held in the DUT
    wb_data_t  j_rows [NUM_SPIN];
    wb_data_t  flip_words [FLIP_DEPTH];
    wb_data_t  hbias;
    spin_vec_t spin_init;
    int        flip_count;
    int        sweeps;

    ising_core_top u_ising_core_top (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // bus access and checking
    task automatic check(input wb_data_t got, input wb_data_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int cycles;
        cycles = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(negedge clk);   // ack and data are sampled mid-cycle
        while (!wb_ack) begin
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                $display("no Wishbone ack within %0d cycles at address %h", ACK_TIMEOUT, adr);
                $display("Test failed");
                $fatal(1, "bus timeout");
            end
            @(negedge clk);
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
        wb_data_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    function automatic wb_addr_t reg_addr(input logic [REG_OFF_W-1:0] off);
        return REG_BASE + wb_addr_t'(off);
    endfunction

    function automatic wb_addr_t word_addr(input wb_addr_t base, input int idx);
        return base + wb_addr_t'(4 * idx);
    endfunction

    task automatic wait_status(input int bit_idx, input string what);
        wb_data_t st;
        int       polls;
        polls = 0;
        wb_read(reg_addr(REG_STATUS), st);
        while (!st[bit_idx]) begin
            polls++;
            if (polls > POLL_TIMEOUT) begin
                $display("%s not seen in STATUS after %0d reads", what, POLL_TIMEOUT);
                $display("Test failed");
                $fatal(1, "status timeout");
            end
            wb_read(reg_addr(REG_STATUS), st);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    function automatic int nibble(input wb_data_t w, input int idx);
        logic signed [3:0] n;
        n = w[idx*4 +: 4];
        return int'(n);
    endfunction

    // sequential updates, +1 when h_k + sum J[k][j]*s_j is not negative
    task automatic run_model(output spin_vec_t result);
        int s [NUM_SPIN];
        int field;
        int k;
        for (int j = 0; j < NUM_SPIN; j++) begin
            s[j] = spin_init[j] ? 1 : -1;
        end
        for (int sw = 0; sw < sweeps; sw++) begin
            for (int f = 0; f < flip_count; f++) begin
                k     = int'(flip_words[f][2:0]);
                field = nibble(hbias, k);
                for (int j = 0; j < NUM_SPIN; j++) begin
                    if (j != k) begin
                        field += nibble(j_rows[k], j) * s[j];
                    end
                end
                s[k] = (field >= 0) ? 1 : -1;
            end
        end
        for (int j = 0; j < NUM_SPIN; j++) begin
            result[j] = (s[j] > 0);
        end
    endtask

    //////////////////////////////////////////////////
    // problem setup
    task automatic new_problem(input int fcnt, input int sw);
        wb_data_t rnd;
        for (int k = 0; k < NUM_SPIN; k++) begin
            j_rows[k] = $random(seed);
        end
        for (int i = 0; i < FLIP_DEPTH; i++) begin
            flip_words[i] = $random(seed);
        end
        hbias      = $random(seed);
        rnd        = $random(seed);
        spin_init  = rnd[7:0];
        flip_count = fcnt;
        sweeps     = sw;
    endtask

    task automatic program_problem();
        for (int k = 0; k < NUM_SPIN; k++) begin
            wb_write(word_addr(J_BASE, k), j_rows[k]);
        end
        for (int i = 0; i < FLIP_DEPTH; i++) begin
            wb_write(word_addr(FLIP_BASE, i), flip_words[i]);
        end
        wb_write(reg_addr(REG_HBIAS), hbias);
        wb_write(reg_addr(REG_SPIN_INIT), wb_data_t'(spin_init));
        wb_write(reg_addr(REG_FLIP_COUNT), wb_data_t'(flip_count));
        wb_write(reg_addr(REG_SWEEPS), wb_data_t'(sweeps));
        wb_write(reg_addr(REG_CTRL), 32'h1);   // load J rows
        wait_status(1, "load_done");
    endtask

    task automatic anneal_and_check(input string what);
        wb_data_t  rd;
        spin_vec_t exp;
        wb_write(reg_addr(REG_CTRL), 32'h2);
        wait_status(2, "anneal_done");
        wb_read(reg_addr(REG_SPIN_STATE), rd);
        run_model(exp);
        check(rd, wb_data_t'(exp), what);
    endtask

    //////////////////////////////////////////////////
    // tests
    task automatic reset_and_readback();
        wb_data_t rd;
        wb_data_t rnd;
        for (int off = 0; off <= 'h18; off += 4) begin
            wb_read(reg_addr(REG_OFF_W'(off)), rd);
            check(rd, '0, $sformatf("register %h after reset", off));
        end
        wb_write(reg_addr(REG_FLIP_COUNT), 32'd9);
        wb_read(reg_addr(REG_FLIP_COUNT), rd);
        check(rd, 32'd9, "FLIP_COUNT readback");
        rnd = $random(seed);
        wb_write(reg_addr(REG_SWEEPS), rnd);
        wb_read(reg_addr(REG_SWEEPS), rd);
        check(rd, {24'h0, rnd[7:0]}, "SWEEPS readback");
        rnd = $random(seed);
        wb_write(reg_addr(REG_HBIAS), rnd);
        wb_read(reg_addr(REG_HBIAS), rd);
        check(rd, rnd, "HBIAS readback");
        rnd = $random(seed);
        wb_write(reg_addr(REG_SPIN_INIT), rnd);
        wb_read(reg_addr(REG_SPIN_INIT), rd);
        check(rd, {24'h0, rnd[7:0]}, "SPIN_INIT readback");
        for (int k = 0; k < NUM_SPIN; k++) begin
            rnd = $random(seed);
            wb_write(word_addr(J_BASE, k), rnd);
            wb_read(word_addr(J_BASE, k), rd);
            check(rd, rnd, $sformatf("J word %0d readback", k));
        end
        for (int i = 0; i < FLIP_DEPTH; i++) begin
            rnd = $random(seed);
            wb_write(word_addr(FLIP_BASE, i), rnd);
            wb_read(word_addr(FLIP_BASE, i), rd);
            check(rd, rnd & 32'h7, $sformatf("flip word %0d readback", i));
        end
        // holes in the map ack and read 0
        wb_write(12'h080, 32'hdeadbeef);
        wb_read(12'h080, rd);
        check(rd, '0, "unmapped 0x080");
        wb_write(12'h300, 32'h12345678);
        wb_read(12'h300, rd);
        check(rd, '0, "unmapped 0x300");
    endtask

    task automatic ferromagnetic_case();
        wb_data_t rd;
        for (int k = 0; k < NUM_SPIN; k++) begin
            j_rows[k] = 32'h1111_1111;
        end
        for (int i = 0; i < FLIP_DEPTH; i++) begin
            flip_words[i] = i % NUM_SPIN;
        end
        hbias      = '0;
        spin_init  = 8'h01;
        flip_count = NUM_SPIN;
        sweeps     = 1;
        program_problem();
        wb_write(reg_addr(REG_CTRL), 32'h2);
        wait_status(2, "anneal_done");
        wb_read(reg_addr(REG_SPIN_STATE), rd);
        check(rd, '0, "ferromagnetic majority");   // each spin sees seven -1 neighbours
    endtask

    task automatic random_problems();
        wb_data_t rnd;
        for (int run = 0; run < 5; run++) begin
            rnd = $random(seed);
            new_problem(1 + int'(rnd[3:0]), 1 + int'(rnd[9:8]) % 3);
            program_problem();
            anneal_and_check($sformatf("random problem %0d", run));
        end
    endtask

    task automatic zero_counts();
        wb_data_t rd;
        new_problem(0, 2);
        program_problem();
        wb_write(reg_addr(REG_CTRL), 32'h2);
        wait_status(2, "anneal_done");
        wb_read(reg_addr(REG_SPIN_STATE), rd);
        check(rd, wb_data_t'(spin_init), "flip count 0");
        new_problem(5, 0);
        program_problem();
        wb_write(reg_addr(REG_CTRL), 32'h2);
        wait_status(2, "anneal_done");
        wb_read(reg_addr(REG_SPIN_STATE), rd);
        check(rd, wb_data_t'(spin_init), "sweep count 0");
    endtask

    task automatic start_while_busy();
        wb_data_t  rd;
        spin_vec_t exp;
        new_problem(FLIP_DEPTH, 3);   // long enough to overlap the accesses below
        program_problem();
        wb_write(reg_addr(REG_CTRL), 32'h2);
        wb_read(reg_addr(REG_STATUS), rd);
        check(wb_data_t'(rd[0]), 32'h1, "busy during anneal");
        wb_write(reg_addr(REG_CTRL), 32'h3);   // dropped while busy
        wb_read(word_addr(J_BASE, 2), rd);
        check(rd, j_rows[2], "J word read during anneal");
        wb_read(word_addr(FLIP_BASE, 5), rd);   // waits for the flip reads to stop
        check(rd, flip_words[5] & 32'h7, "flip word read during anneal");
        wait_status(2, "anneal_done");
        wb_read(reg_addr(REG_SPIN_STATE), rd);
        run_model(exp);
        check(rd, wb_data_t'(exp), "anneal with ignored start");
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        seed     = 32'h50d3476f;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        reset_and_readback();
        ferromagnetic_case();
        random_problems();
        zero_counts();
        start_while_busy();
        $display("Test passed");
        $finish;
    end

endmodule

//--- source/ising_core_top.sv
// single Wishbone classic target; memory acks stretch while the controller owns the read port
`timescale 1ns/1ps

module ising_core_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  ising_bus_pkg::wb_addr_t wb_adr_i,
    input  ising_bus_pkg::wb_data_t wb_dat_i,
    output ising_bus_pkg::wb_data_t wb_dat_o,
    output logic                    wb_ack_o
);
    import ising_cfg_pkg::*;
    import ising_bus_pkg::*;

    ising_wb_if    wb_host ();
    ising_wb_if    wb_j ();
    ising_wb_if    wb_flip ();
    ising_wb_if    wb_reg ();
    ising_array_if arr ();

    logic      j_ren;
    mem_addr_t j_raddr;
    wb_data_t  j_rdata;
    logic      flip_ren;
    mem_addr_t flip_raddr;
    wb_data_t  flip_rdata;
    logic      load_start;
    logic      anneal_start;
    logic      busy;
    logic      load_done;
    logic      anneal_done;
    flip_cnt_t flip_count;
    sweep_t    sweeps;
    spin_vec_t spin_init;
    h_vec_t    hbias;

    // host port onto the internal bus
    assign wb_host.cyc   = wb_cyc_i;
    assign wb_host.stb   = wb_stb_i;
    assign wb_host.we    = wb_we_i;
    assign wb_host.adr   = wb_adr_i;
    assign wb_host.dat_w = wb_dat_i;
    assign wb_dat_o      = wb_host.dat_r;
    assign wb_ack_o      = wb_host.ack;

    //////////////////////////////////////////////////
    // bus and storage
    ising_bus_decode u_bus_decode (
        .clk_i, .rst_n_i,
        .wb_s    (wb_host.slave),
        .wb_j    (wb_j.master),
        .wb_flip (wb_flip.master),
        .wb_reg  (wb_reg.master)
    );

    ising_l1_mem u_j_mem (
        .clk_i, .rst_n_i,
        .wb      (wb_j.slave),
        .ren_i   (j_ren),
        .raddr_i (j_raddr),
        .rdata_o (j_rdata)
    );

    ising_l1_mem u_flip_mem (
        .clk_i, .rst_n_i,
        .wb      (wb_flip.slave),
        .ren_i   (flip_ren),
        .raddr_i (flip_raddr),
        .rdata_o (flip_rdata)
    );

    ising_regs u_regs (
        .clk_i, .rst_n_i,
        .wb             (wb_reg.slave),
        .busy_i         (busy),
        .load_done_i    (load_done),
        .anneal_done_i  (anneal_done),
        .spins_i        (arr.spins),
        .load_start_o   (load_start),
        .anneal_start_o (anneal_start),
        .flip_count_o   (flip_count),
        .sweeps_o       (sweeps),
        .spin_init_o    (spin_init),
        .hbias_o        (hbias)
    );

    //////////////////////////////////////////////////
    // digital macro and spin array
    ising_anneal_ctrl u_anneal_ctrl (
        .clk_i, .rst_n_i,
        .load_start_i   (load_start),
        .anneal_start_i (anneal_start),
        .flip_count_i   (flip_count),
        .sweeps_i       (sweeps),
        .spin_init_i    (spin_init),
        .busy_o         (busy),
        .load_done_o    (load_done),
        .anneal_done_o  (anneal_done),
        .j_ren_o        (j_ren),
        .j_raddr_o      (j_raddr),
        .j_rdata_i      (j_rdata),
        .flip_ren_o     (flip_ren),
        .flip_raddr_o   (flip_raddr),
        .flip_rdata_i   (flip_rdata),
        .arr            (arr.ctrl)
    );

    ising_spin_array u_spin_array (
        .clk_i, .rst_n_i,
        .arr     (arr.array),
        .hbias_i (hbias)
    );

endmodule

//--- source/ising_spin_array.sv
// behavioral stand-in for the analog macro; one spin per cycle, and the J diagonal is ignored
`timescale 1ns/1ps

module ising_spin_array (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    ising_array_if.array          arr,
    input  ising_cfg_pkg::h_vec_t hbias_i
);
    import ising_cfg_pkg::*;

    j_row_t                  j_rows_q [NUM_SPIN];   // row k holds J[k][*]
    spin_vec_t               spins_q;
    j_row_t                  row;                   // couplings of the selected spin
    logic signed [BIT_H-1:0] h_k;
    logic signed [BIT_J-1:0] coup;
    field_t                  field;

    // coupling rows, written by the one-hot word line
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < NUM_SPIN; k++) begin
            if (arr.j_wwl[k]) begin
                j_rows_q[k] <= arr.wbl;
            end
        end
    end

    assign row = j_rows_q[arr.upd_idx];
    assign h_k = hbias_i[arr.upd_idx*BIT_H +: BIT_H];

    // local field: h_k plus J[k][j] for every +1 neighbour, minus it for every -1
    always_comb begin
        field = field_t'(h_k);
        for (int j = 0; j < NUM_SPIN; j++) begin
            coup = row[j*BIT_J +: BIT_J];
            if (j != int'(arr.upd_idx)) begin
                field = spins_q[j] ? field + field_t'(coup) : field - field_t'(coup);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spins_q <= '0;
        end else if (arr.init_we) begin
            spins_q <= arr.init_spins;
        end else if (arr.upd_en) begin
            spins_q[arr.upd_idx] <= (field >= 0);   // ties go to +1
        end
    end

    assign arr.spins = spins_q;

endmodule

//--- source/ising_anneal_ctrl.sv
// J must be loaded before annealing; a flip count or sweep count of 0 only applies spin_init
`timescale 1ns/1ps

module ising_anneal_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     load_start_i,
    input  logic                     anneal_start_i,
    input  ising_cfg_pkg::flip_cnt_t flip_count_i,
    input  ising_cfg_pkg::sweep_t    sweeps_i,
    input  ising_cfg_pkg::spin_vec_t spin_init_i,
    output logic                     busy_o,
    output logic                     load_done_o,
    output logic                     anneal_done_o,
    output logic                     j_ren_o,
    output ising_bus_pkg::mem_addr_t j_raddr_o,
    input  ising_bus_pkg::wb_data_t  j_rdata_i,
    output logic                     flip_ren_o,
    output ising_bus_pkg::mem_addr_t flip_raddr_o,
    input  ising_bus_pkg::wb_data_t  flip_rdata_i,
    ising_array_if.ctrl              arr
);
    import ising_cfg_pkg::*;
    import ising_bus_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,    // J rows into the array
        ST_INIT,    // spin_init into the spin register
        ST_RUN,     // one flip read per cycle
        ST_DRAIN    // last update still in flight
    } state_t;

    state_t     state_q;
    mem_addr_t  row_q;        // next J row, stops at NUM_SPIN
    logic       row_vld_q;    // J data returns this cycle
    spin_idx_t  row_idx_q;
    spin_vec_t  wwl_q;
    j_row_t     wbl_q;
    flip_addr_t flip_ptr_q;
    sweep_t     sweep_q;
    logic       upd_q;
    logic       last_flip;
    logic       last_sweep;

    assign busy_o       = (state_q != ST_IDLE);
    assign j_ren_o      = (state_q == ST_LOAD) && (row_q < NUM_SPIN);
    assign j_raddr_o    = row_q;
    assign flip_ren_o   = (state_q == ST_RUN);
    assign flip_raddr_o = flip_ptr_q;
    assign last_flip    = ({1'b0, flip_ptr_q} == flip_count_i - 1'b1);
    assign last_sweep   = (sweep_q == sweeps_i - 1'b1);

    //////////////////////////////////////////////////
    // array side
    assign arr.j_wwl      = wwl_q;
    assign arr.wbl        = wbl_q;
    assign arr.init_we    = (state_q == ST_INIT);
    assign arr.init_spins = spin_init_i;
    assign arr.upd_en     = upd_q;                                  // read issued last cycle
    assign arr.upd_idx    = flip_rdata_i[$bits(spin_idx_t)-1:0];

    always_ff @(posedge clk_i) begin
        row_idx_q <= row_q[$bits(spin_idx_t)-1:0];
        wbl_q     <= j_rdata_i;
    end

    //////////////////////////////////////////////////
    // sequencer
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q       <= ST_IDLE;
            row_q         <= '0;
            row_vld_q     <= 1'b0;
            wwl_q         <= '0;
            flip_ptr_q    <= '0;
            sweep_q       <= '0;
            upd_q         <= 1'b0;
            load_done_o   <= 1'b0;
            anneal_done_o <= 1'b0;
        end else begin
            load_done_o   <= 1'b0;
            anneal_done_o <= 1'b0;
            row_vld_q     <= j_ren_o;
            wwl_q         <= row_vld_q ? spin_vec_t'(1) << row_idx_q : '0;
            upd_q         <= flip_ren_o;
            case (state_q)
                ST_IDLE: begin
                    row_q <= '0;
                    if (load_start_i) begin
                        state_q <= ST_LOAD;
                    end else if (anneal_start_i) begin
                        state_q <= ST_INIT;
                    end
                end
                ST_LOAD: begin
                    if (j_ren_o) begin
                        row_q <= row_q + 1'b1;
                    end
                    if (wwl_q[NUM_SPIN-1]) begin   // last row written now
                        state_q     <= ST_IDLE;
                        load_done_o <= 1'b1;
                    end
                end
                ST_INIT: begin
                    flip_ptr_q <= '0;
                    sweep_q    <= '0;
                    if (flip_count_i == '0 || sweeps_i == '0) begin
                        state_q       <= ST_IDLE;
                        anneal_done_o <= 1'b1;
                    end else begin
                        state_q <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (last_flip) begin
                        flip_ptr_q <= '0;
                        if (last_sweep) begin
                            state_q <= ST_DRAIN;
                        end else begin
                            sweep_q <= sweep_q + 1'b1;
                        end
                    end else begin
                        flip_ptr_q <= flip_ptr_q + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    state_q       <= ST_IDLE;
                    anneal_done_o <= 1'b1;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- source/ising_regs.sv
// CTRL start bits are dropped while the controller is busy; CTRL and unused offsets read 0
`timescale 1ns/1ps

module ising_regs (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    ising_wb_if.slave                wb,
    input  logic                     busy_i,
    input  logic                     load_done_i,
    input  logic                     anneal_done_i,
    input  ising_cfg_pkg::spin_vec_t spins_i,
    output logic                     load_start_o,
    output logic                     anneal_start_o,
    output ising_cfg_pkg::flip_cnt_t flip_count_o,
    output ising_cfg_pkg::sweep_t    sweeps_o,
    output ising_cfg_pkg::spin_vec_t spin_init_o,
    output ising_cfg_pkg::h_vec_t    hbias_o
);
    import ising_cfg_pkg::*;
    import ising_bus_pkg::*;

    logic                 acc;        // first cycle of an access
    logic                 wr;
    logic                 ctrl_wr;
    logic [REG_OFF_W-1:0] off;
    logic                 ack_q;
    logic                 load_done_q;
    logic                 anneal_done_q;
    wb_data_t             rdata;

    assign acc     = wb.cyc && wb.stb && !ack_q;
    assign wr      = acc && wb.we;
    assign off     = wb.adr[REG_OFF_W-1:0];
    assign ctrl_wr = wr && (off == REG_CTRL) && !busy_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q          <= 1'b0;
            load_start_o   <= 1'b0;
            anneal_start_o <= 1'b0;
            flip_count_o   <= '0;
            sweeps_o       <= '0;
            spin_init_o    <= '0;
            hbias_o        <= '0;
            load_done_q    <= 1'b0;
            anneal_done_q  <= 1'b0;
        end else begin
            ack_q          <= acc;
            load_start_o   <= ctrl_wr && wb.dat_w[0];
            anneal_start_o <= ctrl_wr && wb.dat_w[1];
            if (wr) begin
                case (off)
                    REG_FLIP_COUNT: flip_count_o <= (wb.dat_w > FLIP_DEPTH) ?
                                                    flip_cnt_t'(FLIP_DEPTH) :
                                                    flip_cnt_t'(wb.dat_w);
                    REG_SWEEPS:     sweeps_o     <= sweep_t'(wb.dat_w);
                    REG_HBIAS:      hbias_o      <= wb.dat_w;
                    REG_SPIN_INIT:  spin_init_o  <= spin_vec_t'(wb.dat_w);
                    default: ;
                endcase
            end
            // sticky done flags, any new start clears both
            if (load_start_o || anneal_start_o) begin
                load_done_q   <= 1'b0;
                anneal_done_q <= 1'b0;
            end else begin
                load_done_q   <= load_done_q || load_done_i;
                anneal_done_q <= anneal_done_q || anneal_done_i;
            end
        end
    end

    always_comb begin
        case (off)
            REG_STATUS:     rdata = wb_data_t'({anneal_done_q, load_done_q, busy_i});
            REG_FLIP_COUNT: rdata = wb_data_t'(flip_count_o);
            REG_SWEEPS:     rdata = wb_data_t'(sweeps_o);
            REG_HBIAS:      rdata = hbias_o;
            REG_SPIN_INIT:  rdata = wb_data_t'(spin_init_o);
            REG_SPIN_STATE: rdata = wb_data_t'(spins_i);
            default:        rdata = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (acc) begin
            wb.dat_r <= rdata;
        end
    end

    assign wb.ack = ack_q;

endmodule

//--- source/ising_l1_mem.sv
// the direct read port wins every cycle it is used, so a Wishbone access waits for a free cycle
`timescale 1ns/1ps

module ising_l1_mem (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    ising_wb_if.slave                wb,
    input  logic                     ren_i,
    input  ising_bus_pkg::mem_addr_t raddr_i,
    output ising_bus_pkg::wb_data_t  rdata_o
);
    import ising_bus_pkg::*;

    wb_data_t  mem_q [2**$bits(mem_addr_t)];
    mem_addr_t wb_idx;
    logic      wb_go;    // bus access served in this cycle
    logic      ack_q;

    assign wb_idx = wb.adr[2 +: $bits(mem_addr_t)];   // word index from the byte address
    assign wb_go  = wb.cyc && wb.stb && !ack_q && !ren_i;

    // storage with both read registers
    always_ff @(posedge clk_i) begin
        if (ren_i) begin
            rdata_o <= mem_q[raddr_i];
        end else if (wb_go) begin
            if (wb.we) begin
                mem_q[wb_idx] <= wb.dat_w;
            end
            wb.dat_r <= mem_q[wb_idx];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_go;   // single cycle, the master drops stb on it
        end
    end

    assign wb.ack = ack_q;

endmodule

//--- source/ising_bus_decode.sv
// one classic cycle at a time; unmapped addresses ack after one cycle with data 0 and no write
`timescale 1ns/1ps

module ising_bus_decode (
    input  logic       clk_i,
    input  logic       rst_n_i,
    ising_wb_if.slave  wb_s,
    ising_wb_if.master wb_j,
    ising_wb_if.master wb_flip,
    ising_wb_if.master wb_reg
);
    import ising_bus_pkg::*;

    logic sel_j;
    logic sel_flip;
    logic sel_reg;
    logic none_ack_q;   // local ack for holes in the map

    assign sel_j    = (wb_s.adr >= J_BASE) && (wb_s.adr < J_END);
    assign sel_flip = (wb_s.adr >= FLIP_BASE) && (wb_s.adr < FLIP_END);
    assign sel_reg  = (wb_s.adr >= REG_BASE) && (wb_s.adr < REG_END);

    // request side, strobes go only to the selected target
    assign wb_j.cyc      = wb_s.cyc && sel_j;
    assign wb_j.stb      = wb_s.stb && sel_j;
    assign wb_j.we       = wb_s.we;
    assign wb_j.adr      = wb_s.adr;
    assign wb_j.dat_w    = wb_s.dat_w;

    assign wb_flip.cyc   = wb_s.cyc && sel_flip;
    assign wb_flip.stb   = wb_s.stb && sel_flip;
    assign wb_flip.we    = wb_s.we;
    assign wb_flip.adr   = wb_s.adr;
    assign wb_flip.dat_w = wb_data_t'(wb_s.dat_w[FLIP_BITS-1:0]);  // only the spin index is kept

    assign wb_reg.cyc    = wb_s.cyc && sel_reg;
    assign wb_reg.stb    = wb_s.stb && sel_reg;
    assign wb_reg.we     = wb_s.we;
    assign wb_reg.adr    = wb_s.adr;
    assign wb_reg.dat_w  = wb_s.dat_w;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= wb_s.cyc && wb_s.stb && !(sel_j || sel_flip || sel_reg) && !none_ack_q;
        end
    end

    // response side, adr is held until ack so the select is still valid
    assign wb_s.ack = wb_j.ack || wb_flip.ack || wb_reg.ack || none_ack_q;

    always_comb begin
        if (sel_j) begin
            wb_s.dat_r = wb_j.dat_r;
        end else if (sel_flip) begin
            wb_s.dat_r = wb_flip.dat_r;
        end else if (sel_reg) begin
            wb_s.dat_r = wb_reg.dat_r;
        end else begin
            wb_s.dat_r = '0;
        end
    end

endmodule

//--- source/ising_array_if.sv
// controller to spin array; j_wwl must be one-hot, and init_we takes priority over upd_en
`timescale 1ns/1ps

interface ising_array_if;
    import ising_cfg_pkg::*;

    spin_vec_t j_wwl;       // one-hot row write
    j_row_t    wbl;         // row data
    logic      init_we;
    spin_vec_t init_spins;
    logic      upd_en;
    spin_idx_t upd_idx;     // spin to update
    spin_vec_t spins;

    modport ctrl (output j_wwl, wbl, init_we, init_spins, upd_en, upd_idx,
                  input  spins);
    modport array (input  j_wwl, wbl, init_we, init_spins, upd_en, upd_idx,
                   output spins);

endinterface

//--- source/ising_wb_if.sv
// Wishbone classic, single accesses only; the master holds its request until a one-cycle ack
`timescale 1ns/1ps

interface ising_wb_if;
    import ising_bus_pkg::*;

    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
    wb_data_t dat_r;
    logic     ack;

    modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);
    modport slave  (input cyc, stb, we, adr, dat_w, output dat_r, ack);

endinterface

//--- source/ising_bus_pkg.sv
// 12-bit byte addresses and full 32-bit words only; the low two address bits are ignored
package ising_bus_pkg;

    localparam int WB_ADDR_W = 12;
    localparam int WB_DATA_W = 32;

    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [3:0]           mem_addr_t;  // word index into an L1 memory

    //////////////////////////////////////////////////
    // address map
    localparam wb_addr_t J_BASE     = 12'h000;
    localparam int       J_WORDS    = 8;
    localparam wb_addr_t J_END      = J_BASE + wb_addr_t'(4 * J_WORDS);
    localparam wb_addr_t FLIP_BASE  = 12'h100;
    localparam int       FLIP_WORDS = 16;
    localparam wb_addr_t FLIP_END   = FLIP_BASE + wb_addr_t'(4 * FLIP_WORDS);
    localparam int       FLIP_BITS  = 3;       // stored width of a flip entry
    localparam wb_addr_t REG_BASE   = 12'h200;
    localparam int       REG_OFF_W  = 5;       // 32-byte register window
    localparam wb_addr_t REG_END    = REG_BASE + wb_addr_t'(2 ** REG_OFF_W);

    // register offsets
    localparam logic [REG_OFF_W-1:0] REG_CTRL       = 5'h00;
    localparam logic [REG_OFF_W-1:0] REG_STATUS     = 5'h04;
    localparam logic [REG_OFF_W-1:0] REG_FLIP_COUNT = 5'h08;
    localparam logic [REG_OFF_W-1:0] REG_SWEEPS     = 5'h0C;
    localparam logic [REG_OFF_W-1:0] REG_HBIAS      = 5'h10;
    localparam logic [REG_OFF_W-1:0] REG_SPIN_INIT  = 5'h14;
    localparam logic [REG_OFF_W-1:0] REG_SPIN_STATE = 5'h18;

endpackage

//--- source/ising_cfg_pkg.sv
// all problem sizes are fixed here; a spin bit of 1 stands for +1, J and h are two's complement
package ising_cfg_pkg;

    localparam int NUM_SPIN   = 8;
    localparam int BIT_J      = 4;   // signed coupling
    localparam int BIT_H      = 4;   // signed bias
    localparam int FLIP_DEPTH = 16;  // flip-list entries

    // one bit per spin
    typedef logic [NUM_SPIN-1:0]         spin_vec_t;
    typedef logic [$clog2(NUM_SPIN)-1:0] spin_idx_t;

    // row k of J, nibble j holds J[k][j]
    typedef logic [NUM_SPIN*BIT_J-1:0] j_row_t;
    // nibble k holds h_k
    typedef logic [NUM_SPIN*BIT_H-1:0] h_vec_t;

    typedef logic [$clog2(FLIP_DEPTH)-1:0]   flip_addr_t;
    typedef logic [$clog2(FLIP_DEPTH+1)-1:0] flip_cnt_t;   // 0 to FLIP_DEPTH
    typedef logic [7:0]                      sweep_t;

    // h plus seven couplings stays within +-64
    typedef logic signed [7:0] field_t;

endpackage
